//--- Makefile
VERILATOR ?= verilator
TOP       ?= dm_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG SEED VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
common/dm_pkg.sv
display/glyph_rom.sv
display/matrix_scan.sv
display/cmd_queue.sv
logic/disp_regs.sv
logic/dm_top.sv
test/dm_checks.sv
test/dm_tb.sv

//--- common/dm_pkg.sv
package dm_pkg;

    localparam int ROWS       = 8;
    localparam int COLS       = 8;
    localparam int ROW_W      = $clog2(ROWS);
    localparam int GLYPH_W    = 4;
    localparam int NUM_GLYPHS = 12;   // 12..15 are blank
    localparam int CREDITS    = 2;    // queue depth, sender's starting credits
    localparam int PTR_W      = $clog2(CREDITS);
    localparam int LVL_W      = $clog2(CREDITS + 1);

    localparam logic [GLYPH_W-1:0] BLANK_GLYPH = '1;

    typedef enum logic {
        op_show  = 1'b0,
        op_clear = 1'b1
    } cmd_op_e;

    // ctrl: bit0 enable, bit1 alert
    // status: queue level in the low bits
    typedef enum logic {
        reg_ctrl   = 1'b0,
        reg_status = 1'b1
    } reg_addr_e;

endpackage

//--- display/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic                       cmd_valid,
    input  dm_pkg::cmd_op_e            cmd_op,
    input  logic [dm_pkg::GLYPH_W-1:0] cmd_glyph,
    input  logic                       frame_end,
    output logic                       head_valid,
    output dm_pkg::cmd_op_e            head_op,
    output logic [dm_pkg::GLYPH_W-1:0] head_glyph,
    output logic [dm_pkg::LVL_W-1:0]   level,
    output logic                       cmd_credit
);

    dm_pkg::cmd_op_e            op_mem    [dm_pkg::CREDITS];
    logic [dm_pkg::GLYPH_W-1:0] glyph_mem [dm_pkg::CREDITS];
    logic [dm_pkg::PTR_W-1:0]   wr_ptr;
    logic [dm_pkg::PTR_W-1:0]   rd_ptr;
    logic                       push;
    logic                       pop;

    assign push       = cmd_valid;   // credits guarantee room
    assign pop        = enable && frame_end && head_valid;
    assign head_valid = (level != '0);
    assign head_op    = op_mem[rd_ptr];
    assign head_glyph = glyph_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            op_mem[wr_ptr]    <= cmd_op;
            glyph_mem[wr_ptr] <= cmd_glyph;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == dm_pkg::PTR_W'(dm_pkg::CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == dm_pkg::PTR_W'(dm_pkg::CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            cmd_credit <= pop;   // one credit back per consumed command
        end
    end

    // sender only gets a credit back a cycle after the pop
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> level < dm_pkg::LVL_W'(dm_pkg::CREDITS));

    a_level_max: assert property (@(posedge clk) disable iff (rst)
        level <= dm_pkg::LVL_W'(dm_pkg::CREDITS));

endmodule

//--- display/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  logic [dm_pkg::GLYPH_W-1:0] glyph,
    input  logic [dm_pkg::ROW_W-1:0]   row_idx,
    output logic [dm_pkg::COLS-1:0]    bits
);

    always_comb
    begin
        bits = '0;
        if (glyph < dm_pkg::NUM_GLYPHS)
        begin
            case (glyph)
                // flame levels, mirrored top to bottom
                4'd0:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0001_1000;
                        3'd3, 3'd4: bits = 8'b0011_1100;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                4'd1:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0011_1000;
                        3'd3, 3'd4: bits = 8'b0111_1100;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                4'd2:
                begin
                    case (row_idx)
                        3'd2, 3'd5: bits = 8'b0011_1100;
                        3'd3, 3'd4: bits = 8'b0111_1110;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                4'd3:
                begin
                    case (row_idx)
                        3'd1, 3'd6:             bits = 8'b0011_1100;
                        3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                        default:                bits = 8'b0000_0000;
                    endcase
                end
                4'd4:
                begin
                    case (row_idx)
                        3'd0, 3'd7: bits = 8'b0011_1100;
                        3'd1, 3'd6: bits = 8'b0111_1110;
                        default:    bits = 8'b1111_1111;
                    endcase
                end
                4'd5: bits = '1;   // full panel
                4'd6:
                begin
                    case (row_idx)   // thermometer
                        3'd0:             bits = 8'b0001_1000;
                        3'd1, 3'd2, 3'd3: bits = 8'b0010_0100;
                        3'd4, 3'd7:       bits = 8'b0011_1100;
                        default:          bits = 8'b0111_1110;
                    endcase
                end
                4'd7:
                begin
                    case (row_idx)   // heart
                        3'd1:       bits = 8'b0110_0110;
                        3'd2, 3'd3: bits = 8'b1111_1111;
                        3'd4:       bits = 8'b0111_1110;
                        3'd5:       bits = 8'b0011_1100;
                        3'd6:       bits = 8'b0001_1000;
                        default:    bits = 8'b0000_0000;
                    endcase
                end
                4'd8:
                begin
                    case (row_idx)   // smiley
                        3'd0, 3'd7: bits = 8'b0011_1100;
                        3'd1, 3'd6: bits = 8'b0100_0010;
                        3'd2, 3'd4: bits = 8'b1010_0101;
                        3'd3:       bits = 8'b1000_0001;
                        default:    bits = 8'b1001_1001;
                    endcase
                end
                4'd9:
                begin
                    case (row_idx)   // arrow up
                        3'd0:    bits = 8'b0001_1000;
                        3'd1:    bits = 8'b0011_1100;
                        3'd2:    bits = 8'b0111_1110;
                        3'd3:    bits = 8'b1101_1011;
                        default: bits = 8'b0001_1000;
                    endcase
                end
                4'd10:
                begin
                    case (row_idx)   // cross
                        3'd0, 3'd7: bits = 8'b1000_0001;
                        3'd1, 3'd6: bits = 8'b0100_0010;
                        3'd2, 3'd5: bits = 8'b0010_0100;
                        default:    bits = 8'b0001_1000;
                    endcase
                end
                4'd11:
                begin
                    case (row_idx)   // tick
                        3'd1:    bits = 8'b0000_0001;
                        3'd2:    bits = 8'b0000_0010;
                        3'd3:    bits = 8'b0000_0100;
                        3'd4:    bits = 8'b1000_1000;
                        3'd5:    bits = 8'b0101_0000;
                        3'd6:    bits = 8'b0010_0000;
                        default: bits = 8'b0000_0000;
                    endcase
                end
                default: bits = '0;
            endcase
        end
    end

endmodule

//--- display/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic                       alert,
    input  logic                       head_valid,
    input  dm_pkg::cmd_op_e            head_op,
    input  logic [dm_pkg::GLYPH_W-1:0] head_glyph,
    input  logic [dm_pkg::COLS-1:0]    pattern,
    output logic                       frame_end,
    output logic [dm_pkg::GLYPH_W-1:0] glyph,
    output logic [dm_pkg::ROW_W-1:0]   row_idx,
    output logic [dm_pkg::ROWS-1:0]    row,
    output logic [dm_pkg::COLS-1:0]    colg,
    output logic [dm_pkg::COLS-1:0]    colr
);

    logic [dm_pkg::ROW_W-1:0] cnt;

    assign frame_end = (cnt == dm_pkg::ROW_W'(dm_pkg::ROWS - 1));
    assign row_idx   = cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (!enable)
            cnt <= '0;   // parked on row 0
        else if (frame_end)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // new picture only at the wrap, so a frame never mixes two glyphs
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            glyph <= dm_pkg::BLANK_GLYPH;
        else if (!enable)
            glyph <= dm_pkg::BLANK_GLYPH;
        else if (frame_end && head_valid)
            glyph <= (head_op == dm_pkg::op_clear) ? dm_pkg::BLANK_GLYPH : head_glyph;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (!enable)
        begin
            row  <= '1;   // all rows off
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~(dm_pkg::ROWS'(1) << cnt);   // active low select
            colg <= pattern;
            colr <= alert ? pattern : '0;         // red follows green on alert
        end
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        $countones(~row) <= 1);

endmodule

//--- logic/disp_regs.sv
`timescale 1ns/1ps

module disp_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     reg_wr,
    input  dm_pkg::reg_addr_e        reg_addr,
    input  logic [7:0]               reg_wdata,
    input  logic [dm_pkg::LVL_W-1:0] level,
    output logic [7:0]               reg_rdata,
    output logic                     enable,
    output logic                     alert
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            enable <= 1'b0;
            alert  <= 1'b0;
        end
        else if (reg_wr && reg_addr == dm_pkg::reg_ctrl)
        begin
            enable <= reg_wdata[0];
            alert  <= reg_wdata[1];
        end
    end

    // status writes are dropped
    always_comb
    begin
        case (reg_addr)
            dm_pkg::reg_ctrl:   reg_rdata = {6'b0, alert, enable};
            dm_pkg::reg_status: reg_rdata = 8'(level);
            default:            reg_rdata = '0;
        endcase
    end

endmodule

//--- logic/dm_top.sv
`timescale 1ns/1ps

module dm_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  dm_pkg::cmd_op_e            cmd_op,
    input  logic [dm_pkg::GLYPH_W-1:0] cmd_glyph,
    output logic                       cmd_credit,
    input  logic                       reg_wr,
    input  dm_pkg::reg_addr_e          reg_addr,
    input  logic [7:0]                 reg_wdata,
    output logic [7:0]                 reg_rdata,
    output logic [dm_pkg::ROWS-1:0]    row,
    output logic [dm_pkg::COLS-1:0]    colg,
    output logic [dm_pkg::COLS-1:0]    colr
);

    logic                       enable;
    logic                       alert;
    logic [dm_pkg::LVL_W-1:0]   level;
    logic                       head_valid;
    dm_pkg::cmd_op_e            head_op;
    logic [dm_pkg::GLYPH_W-1:0] head_glyph;
    logic                       frame_end;
    logic [dm_pkg::GLYPH_W-1:0] glyph;
    logic [dm_pkg::ROW_W-1:0]   row_idx;
    logic [dm_pkg::COLS-1:0]    pattern;

    cmd_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_glyph  (cmd_glyph),
        .frame_end  (frame_end),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_glyph (head_glyph),
        .level      (level),
        .cmd_credit (cmd_credit)
    );

    disp_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .level     (level),
        .reg_rdata (reg_rdata),
        .enable    (enable),
        .alert     (alert)
    );

    matrix_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .alert      (alert),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_glyph (head_glyph),
        .pattern    (pattern),
        .frame_end  (frame_end),
        .glyph      (glyph),
        .row_idx    (row_idx),
        .row        (row),
        .colg       (colg),
        .colr       (colr)
    );

    glyph_rom u_rom (
        .glyph   (glyph),
        .row_idx (row_idx),
        .bits    (pattern)
    );

endmodule

//--- test/dm_checks.sv
`timescale 1ns/1ps

// watches the DUT ports and keeps its own model of ctrl bits, credits and the shown glyph
module dm_checks (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  dm_pkg::cmd_op_e            cmd_op,
    input  logic [dm_pkg::GLYPH_W-1:0] cmd_glyph,
    input  logic                       cmd_credit,
    input  logic                       reg_wr,
    input  dm_pkg::reg_addr_e          reg_addr,
    input  logic [7:0]                 reg_wdata,
    input  logic [7:0]                 reg_rdata,
    input  logic [dm_pkg::ROWS-1:0]    row,
    input  logic [dm_pkg::COLS-1:0]    colg,
    input  logic [dm_pkg::COLS-1:0]    colr
);

    int                         mismatches = 0;
    int                         failures   = 0;
    int                         owed;   // sent, not yet credited
    logic                       en_m;
    logic                       al_m;
    logic                       en_d1;
    logic                       en_d2;
    logic                       al_d1;
    logic                       rst_d;
    logic                       shown_blank;
    logic [dm_pkg::GLYPH_W-1:0] shown_glyph;
    logic [dm_pkg::GLYPH_W:0]   sent_q [$];   // {op, glyph}
    logic [dm_pkg::ROWS-1:0]    row_prev;
    logic [dm_pkg::COLS-1:0]    seen [dm_pkg::ROWS];
    logic [dm_pkg::ROW_W-1:0]   ridx;
    logic [dm_pkg::ROWS-1:0]    row_exp;
    logic [dm_pkg::COLS-1:0]    colg_exp;
    logic [dm_pkg::COLS-1:0]    colr_exp;
    logic [dm_pkg::COLS-1:0]    mirror;
    logic [7:0]                 rdata_exp;
    logic                       shown_full;
    logic                       shown_sym;

    task automatic count_mismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] exp);
        mismatches++;
        $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic count_failure(input string what);
        failures++;
        $display("error: %s at %0t", what, $time);
    endtask

    always_comb
    begin
        ridx = '0;
        for (int i = 0; i < dm_pkg::ROWS; i++)
            if (!row[i])
                ridx = dm_pkg::ROW_W'(i);
        if (!en_d1)
            row_exp = '1;
        else if (!en_d2)
            row_exp = 8'hfe;   // counter parked on row 0 while off
        else
            row_exp = {row_prev[6:0], row_prev[7]};
        shown_full = !shown_blank && shown_glyph == 4'd5;
        shown_sym  = !shown_blank && shown_glyph < 4'd5;
        colg_exp   = (en_d1 && shown_full) ? 8'hff : 8'h00;
        colr_exp   = al_d1 ? colg : 8'h00;
        mirror     = seen[3'd7 - ridx];
        rdata_exp  = (reg_addr == dm_pkg::reg_ctrl) ? {6'b0, al_m, en_m}
                                                    : 8'(owed - int'(cmd_credit));
    end

    always @(posedge clk)
        rst_d <= rst;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            en_m        <= 1'b0;
            al_m        <= 1'b0;
            en_d1       <= 1'b0;
            en_d2       <= 1'b0;
            al_d1       <= 1'b0;
            owed        <= 0;
            shown_blank <= 1'b1;
            shown_glyph <= '0;
            row_prev    <= '1;
            sent_q.delete();
        end
        else
        begin
            if (reg_wr && reg_addr == dm_pkg::reg_ctrl)
            begin
                en_m <= reg_wdata[0];
                al_m <= reg_wdata[1];
            end
            en_d1    <= en_m;
            en_d2    <= en_d1;
            al_d1    <= al_m;
            row_prev <= row;
            owed     <= owed + int'(cmd_valid) - int'(cmd_credit);
            if (en_d1)
                seen[ridx] <= colg;
            if (cmd_valid)
                sent_q.push_back({cmd_op, cmd_glyph});
            // credited command owns the screen from the next sample on
            if (cmd_credit && sent_q.size() > 0)
            begin
                shown_blank <= dm_pkg::cmd_op_e'(sent_q[0][dm_pkg::GLYPH_W]) == dm_pkg::op_clear
                            || sent_q[0][dm_pkg::GLYPH_W-1:0] >= 4'(dm_pkg::NUM_GLYPHS);
                shown_glyph <= sent_q[0][dm_pkg::GLYPH_W-1:0];
                void'(sent_q.pop_front());
            end
            if (!en_m)
                shown_blank <= 1'b1;   // glyph dropped while off
        end
    end

    // from the first edge that saw reset through the edge after its release
    a_reset_idle: assert property (@(posedge clk)
        rst_d |-> (row == '1 && colg == '0 && colr == '0 && !cmd_credit))
        else count_failure("outputs not idle during or right after reset");

    a_row: assert property (@(posedge clk) disable iff (rst) row == row_exp)
        else count_mismatch("row", $sampled(row), $sampled(row_exp));

    a_colg_fixed: assert property (@(posedge clk) disable iff (rst)
        (!en_d1 || shown_blank || shown_full) |-> colg == colg_exp)
        else count_mismatch("colg", $sampled(colg), $sampled(colg_exp));

    a_colg_mirror: assert property (@(posedge clk) disable iff (rst)
        (en_d1 && shown_sym && ridx >= 3'd4) |-> colg == mirror)
        else count_mismatch("colg", $sampled(colg), $sampled(mirror));

    a_colr: assert property (@(posedge clk) disable iff (rst) colr == colr_exp)
        else count_mismatch("colr", $sampled(colr), $sampled(colr_exp));

    a_credit_owed: assert property (@(posedge clk) disable iff (rst) cmd_credit |-> owed > 0)
        else count_failure("credit returned with no command outstanding");

    a_credit_spent: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> owed < dm_pkg::CREDITS)
        else count_failure("command sent without a credit");

    a_rdata: assert property (@(posedge clk) disable iff (rst) reg_rdata == rdata_exp)
        else count_mismatch("reg_rdata", $sampled(reg_rdata), $sampled(rdata_exp));

endmodule

//--- test/dm_tb.sv
`timescale 1ns/1ps

module dm_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int N_CMDS         = 24;
    localparam int FRAME          = dm_pkg::ROWS;
    localparam int TIMEOUT_CYCLES = N_CMDS * 2 * FRAME + 200;

    logic                       clk       = 1'b0;
    logic                       rst       = 1'b1;
    logic                       cmd_valid = 1'b0;
    dm_pkg::cmd_op_e            cmd_op    = dm_pkg::op_show;
    logic [dm_pkg::GLYPH_W-1:0] cmd_glyph = '0;
    logic                       cmd_credit;
    logic                       reg_wr    = 1'b0;
    logic                       read_sel  = 1'b0;
    dm_pkg::reg_addr_e          reg_addr;
    logic [7:0]                 reg_wdata = '0;
    logic [7:0]                 reg_rdata;
    logic [dm_pkg::ROWS-1:0]    row;
    logic [dm_pkg::COLS-1:0]    colg;
    logic [dm_pkg::COLS-1:0]    colr;
    logic [31:0]                lcg_state = 32'hcfbb;
    int                         sent      = 0;
    int                         returned  = 0;

    // reads alternate between ctrl and status when no write is going on
    assign reg_addr = (reg_wr || !read_sel) ? dm_pkg::reg_ctrl : dm_pkg::reg_status;

    dm_top DUT (.*);

    dm_checks checks (.*);

    initial
    begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always
    begin
        @(posedge clk);
        #1;
        read_sel = ~read_sel;
    end

    always @(negedge clk)
        if (!rst && cmd_credit)
            returned++;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic write_ctrl(input logic [1:0] bits);
        reg_wr    = 1'b1;
        reg_wdata = {6'b0, bits};
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic send_cmd(input dm_pkg::cmd_op_e op, input logic [dm_pkg::GLYPH_W-1:0] g);
        while (sent - returned >= dm_pkg::CREDITS)
        begin
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_glyph = g;
        sent++;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_credits_home();
        @(posedge clk);
        while (sent != returned)
            @(posedge clk);
        #1;
    endtask

    initial
    begin
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        write_ctrl(2'b01);
        send_cmd(dm_pkg::op_show, 4'd5);
        send_cmd(dm_pkg::op_show, 4'd2);
        send_cmd(dm_pkg::op_clear, 4'd7);
        for (int i = 3; i < N_CMDS; i++)
        begin
            if (i == N_CMDS / 2)
                write_ctrl(2'b11);   // alert on halfway
            lcg_state = lcg_next(lcg_state);
            send_cmd(lcg_state[23:21] == 3'd0 ? dm_pkg::op_clear : dm_pkg::op_show,
                     lcg_state[19:16]);
        end
        wait_credits_home();
        write_ctrl(2'b10);
        send_cmd(dm_pkg::op_show, 4'd5);   // waits in the queue while dark
        repeat (2 * FRAME) @(posedge clk);
        #1;
        write_ctrl(2'b01);
        wait_credits_home();
        repeat (2 * FRAME) @(posedge clk);
        $display("%0d commands, %0d mismatches, %0d other failures",
                 sent, checks.mismatches, checks.failures);
        if (checks.mismatches + checks.failures == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule
